//--- design/ch_dpram.sv
//##############################
// two-port channel ram shared by
// the source and destination fifos.
//##############################

`include "dma_ch_defines.svh"

module ch_dpram
(
   input  logic                 wb_clk_i,
   fifo_port_if.ram             src_i,
   fifo_port_if.ram             dst_i,
   output dma_ch_pkg::ch_word_t src_rdata_o,
   output dma_ch_pkg::ch_word_t dst_rdata_o,
   output logic                 port_a_busy_o,
   output logic                 port_b_busy_o
);

   import dma_ch_pkg::*;

   ch_word_t  mem [2*`CH_DEPTH];
   ram_addr_t addr_a;
   ram_addr_t addr_b;

   // port a serves source writes, else destination reads.
   assign addr_a = src_i.wallow ? {SRC_HALF, src_i.waddr} : {DST_HALF, dst_i.raddr};
   // port b serves destination writes, else source reads.
   assign addr_b = dst_i.wallow ? {DST_HALF, dst_i.waddr} : {SRC_HALF, src_i.raddr};

   assign port_a_busy_o = src_i.wallow;
   assign port_b_busy_o = dst_i.wallow;

   // the two ports always address different halves when both write.
   always_ff @(posedge wb_clk_i)
   begin
      if (src_i.wallow)
         mem[addr_a] <= src_i.wdata;
      if (dst_i.wallow)
         mem[addr_b] <= dst_i.wdata;
      if (dst_i.rallow)
         dst_rdata_o <= mem[addr_a];     // holds until the next accepted read.
      if (src_i.rallow)
         src_rdata_o <= mem[addr_b];
   end

   // the controllers must see the busy flag before granting a read.
   a_port_a_single_use : assert property (@(posedge wb_clk_i)
      !(src_i.wallow && dst_i.rallow));

   a_port_b_single_use : assert property (@(posedge wb_clk_i)
      !(dst_i.wallow && src_i.rallow));

endmodule

//--- design/dma_ch.sv
//##############################
// dma channel buffer between the bus
// side dma engine and the module.
//##############################

module dma_ch
(
   input  logic        wb_clk_i,
   input  logic        m_reset,

   // bus side, source direction.
   input  logic        src_xfer_i,
   input  logic        src_last_i,
   input  logic [31:0] src_dat_i,
   input  logic [31:0] src_dat64_i,
   output logic        src_stop_o,
   output logic        src_start_o,

   // bus side, destination direction.
   input  logic        dst_xfer_i,
   output logic [31:0] dst_dat_o,
   output logic [31:0] dst_dat64_o,
   output logic        dst_vld_o,
   output logic        dst_end_o,
   output logic        dst_stop_o,
   output logic        dst_start_o,

   // module side, source direction.
   input  logic        m_src_getn_i,
   output logic [63:0] m_src_o,
   output logic        m_src_last_o,
   output logic        m_src_vld_o,
   output logic        m_src_almost_empty_o,
   output logic        m_src_empty_o,

   // module side, destination direction.
   input  logic        m_dst_putn_i,
   input  logic [63:0] m_dst_i,
   input  logic        m_dst_last_i,
   output logic        m_dst_almost_full_o,
   output logic        m_dst_full_o,
   input  logic        m_end_n_i,
   output logic [15:0] ocnt_o
);

   import dma_ch_pkg::*;

   ch_word_t src_rdata;
   ch_word_t dst_rdata;
   logic     src_half_full;
   logic     src_almost_full;
   logic     dst_half_full;
   logic     dst_empty;
   logic     port_a_busy;
   logic     port_b_busy;

   fifo_port_if src_port ();
   fifo_port_if dst_port ();

   //##############################
   // fifo control
   //##############################

   // source fifo: written by the bus, read by the module.
   fifo_ptr_ctrl src_ctrl
   (
      .wb_clk_i       (wb_clk_i),
      .m_reset        (m_reset),
      .wr_en_i        (src_xfer_i),
      .rd_en_i        (~m_src_getn_i),
      .rd_block_i     (port_b_busy),        // source reads use port b.
      .port_o         (src_port),
      .empty_o        (m_src_empty_o),
      .almost_empty_o (m_src_almost_empty_o),
      .half_full_o    (src_half_full),
      .almost_full_o  (src_almost_full),
      .full_o         (),
      .rd_vld_o       (m_src_vld_o)
   );

   // destination fifo: written by the module, read by the bus.
   fifo_ptr_ctrl dst_ctrl
   (
      .wb_clk_i       (wb_clk_i),
      .m_reset        (m_reset),
      .wr_en_i        (~m_dst_putn_i),
      .rd_en_i        (dst_xfer_i),
      .rd_block_i     (port_a_busy),        // destination reads use port a.
      .port_o         (dst_port),
      .empty_o        (dst_empty),
      .almost_empty_o (dst_stop_o),
      .half_full_o    (dst_half_full),
      .almost_full_o  (m_dst_almost_full_o),
      .full_o         (m_dst_full_o),
      .rd_vld_o       (dst_vld_o)
   );

   //##############################
   // shared storage
   //##############################

   ch_dpram ram0
   (
      .wb_clk_i      (wb_clk_i),
      .src_i         (src_port),
      .dst_i         (dst_port),
      .src_rdata_o   (src_rdata),
      .dst_rdata_o   (dst_rdata),
      .port_a_busy_o (port_a_busy),
      .port_b_busy_o (port_b_busy)
   );

   //##############################
   // data path
   //##############################

   assign src_port.wdata = {src_last_i, src_dat64_i, src_dat_i};  // dat64 is the high half.
   assign dst_port.wdata = {m_dst_last_i, m_dst_i};

   assign m_src_o      = {src_rdata.hi, src_rdata.lo};
   assign m_src_last_o = src_rdata.last;

   assign dst_dat64_o = dst_rdata.hi;
   assign dst_dat_o   = dst_rdata.lo;
   assign dst_end_o   = dst_rdata.last;     // qualified by dst_vld_o.

   //##############################
   // bus side levels
   //##############################

   assign src_stop_o  = src_almost_full;
   assign src_start_o = ~src_half_full;

   // a finished module flushes whatever is left in the destination fifo.
   assign dst_start_o = dst_half_full | (~m_end_n_i & ~dst_empty);

   //##############################
   // output word counter
   //##############################

   always_ff @(posedge wb_clk_i)
   begin
      if (m_reset)
         ocnt_o <= '0;
      else if (dst_port.wallow && !m_dst_last_i)
         ocnt_o <= ocnt_o + 1'b1;           // only accepted non-last results count.
   end

endmodule

//--- design/dma_ch_defines.svh
//##############################
// dma channel buffer sizing and
// fifo level flag thresholds.
//##############################

`ifndef DMA_CH_DEFINES_SVH
`define DMA_CH_DEFINES_SVH

//##############################
// fifo geometry
//##############################

`define CH_ADDR_W 4                      // each fifo holds 2**4 words.
`define CH_DEPTH (1 << `CH_ADDR_W)       // words per fifo half of the ram.

//##############################
// level flag thresholds
//##############################

`define CH_AE_LEVEL 2                    // almost empty at or below this count.
`define CH_AF_LEVEL (`CH_DEPTH - 2)      // almost full at or above this count.
`define CH_HALF_LEVEL (`CH_DEPTH / 2)    // half full at or above this count.

`endif

//--- design/dma_ch_pkg.sv
//##############################
// dma channel word layout and
// fifo and ram address types.
//##############################

`include "dma_ch_defines.svh"

package dma_ch_pkg;

   //##############################
   // stored word
   //##############################

   // one ram entry: a 64-bit word split in bus halves plus the last flag.
   typedef struct packed
   {
      logic        last;                 // marks the final word of a block.
      logic [31:0] hi;                   // dat64 half on the bus side.
      logic [31:0] lo;                   // dat half on the bus side.
   } ch_word_t;

   //##############################
   // addressing
   //##############################

   typedef logic [`CH_ADDR_W-1:0] fifo_addr_t;   // pointer inside one fifo.
   typedef logic [`CH_ADDR_W:0]   ram_addr_t;    // half select bit plus pointer.
   typedef logic [`CH_ADDR_W:0]   fifo_cnt_t;    // occupancy, 0 up to CH_DEPTH.

   // the top ram address bit picks which fifo owns the entry.
   localparam logic SRC_HALF = 1'b1;
   localparam logic DST_HALF = 1'b0;

endpackage

//--- design/fifo_port_if.sv
//##############################
// ram access signals of one fifo.
//##############################

interface fifo_port_if;

   import dma_ch_pkg::*;

   fifo_addr_t waddr;                    // write pointer of the fifo.
   fifo_addr_t raddr;                    // read pointer of the fifo.
   logic       wallow;                   // write accepted this cycle.
   logic       rallow;                   // read accepted this cycle.
   ch_word_t   wdata;                    // packed by the channel top level.

   // pointer controller side. the write data comes from the top level.
   modport ctrl
   (
      output waddr,
      output raddr,
      output wallow,
      output rallow
   );

   // shared ram side.
   modport ram
   (
      input waddr,
      input raddr,
      input wallow,
      input rallow,
      input wdata
   );

endinterface

//--- design/fifo_ptr_ctrl.sv
//##############################
// fifo pointer, count and level
// flag control for one channel fifo.
//##############################

`include "dma_ch_defines.svh"

module fifo_ptr_ctrl
(
   input  logic      wb_clk_i,
   input  logic      m_reset,
   input  logic      wr_en_i,
   input  logic      rd_en_i,
   input  logic      rd_block_i,
   fifo_port_if.ctrl port_o,
   output logic      empty_o,
   output logic      almost_empty_o,
   output logic      half_full_o,
   output logic      almost_full_o,
   output logic      full_o,
   output logic      rd_vld_o
);

   import dma_ch_pkg::*;

   fifo_addr_t wptr_q;
   fifo_addr_t rptr_q;
   fifo_cnt_t  cnt_q;
   fifo_cnt_t  cnt_nxt;
   logic       wallow;
   logic       rallow;

   //##############################
   // accept rules
   //##############################

   assign wallow = wr_en_i & ~full_o;                 // a write into a full fifo is dropped.
   assign rallow = rd_en_i & ~empty_o & ~rd_block_i;  // the shared ram port may be taken.

   assign port_o.wallow = wallow;
   assign port_o.rallow = rallow;
   assign port_o.waddr  = wptr_q;
   assign port_o.raddr  = rptr_q;

   always_comb
   begin
      case ({wallow, rallow})
         2'b10:   cnt_nxt = cnt_q + 1'b1;
         2'b01:   cnt_nxt = cnt_q - 1'b1;
         default: cnt_nxt = cnt_q;             // both or neither leave the count.
      endcase
   end

   //##############################
   // pointers and count
   //##############################

   // pointers wrap by themselves at the fifo depth.
   always_ff @(posedge wb_clk_i)
   begin
      if (m_reset)
      begin
         wptr_q <= '0;
         rptr_q <= '0;
         cnt_q  <= '0;
      end
      else
      begin
         if (wallow)
            wptr_q <= wptr_q + 1'b1;
         if (rallow)
            rptr_q <= rptr_q + 1'b1;
         cnt_q <= cnt_nxt;
      end
   end

   //##############################
   // registered flags
   //##############################

   // flags are taken from the next count so they match the count after the edge.
   always_ff @(posedge wb_clk_i)
   begin
      if (m_reset)
      begin
         empty_o        <= 1'b1;
         almost_empty_o <= 1'b1;
         half_full_o    <= 1'b0;
         almost_full_o  <= 1'b0;
         full_o         <= 1'b0;
         rd_vld_o       <= 1'b0;
      end
      else
      begin
         empty_o        <= (cnt_nxt == '0);
         almost_empty_o <= (cnt_nxt <= `CH_AE_LEVEL);
         half_full_o    <= (cnt_nxt >= `CH_HALF_LEVEL);
         almost_full_o  <= (cnt_nxt >= `CH_AF_LEVEL);
         full_o         <= (cnt_nxt == `CH_DEPTH);
         rd_vld_o       <= rallow;             // ram data shows up one cycle later.
      end
   end

   // the writer must have honoured the stop level well before the fifo filled.
   a_no_write_when_full : assert property (@(posedge wb_clk_i) disable iff (m_reset)
      !(wr_en_i && full_o));

   a_count_bound : assert property (@(posedge wb_clk_i) disable iff (m_reset)
      cnt_q <= `CH_DEPTH);

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the dma channel testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps -j 0 \
   --top-module tb_top -Mdir obj_dir -o sim_tb -f tb.f
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "Everything OK" "$LOG"; then
   exit 0
fi

echo "pass message not found in $LOG"
exit 1

//--- tb.f
+incdir+design
design/dma_ch_pkg.sv
design/fifo_port_if.sv
design/fifo_ptr_ctrl.sv
design/ch_dpram.sv
design/dma_ch.sv
verif/ch_checker.sv
verif/tb_top.sv

//--- verif/ch_checker.sv
//##############################
// dma channel checker comparing
// the dut against the model.
//##############################

`include "dma_ch_defines.svh"

module ch_checker
(
   input  logic        wb_clk_i,
   input  logic        check_en_i,
   input  logic        m_end_n_i,
   input  int          src_cnt_i,
   input  int          dst_cnt_i,
   input  logic [7:0]  flags_i,
   input  logic [15:0] exp_ocnt_i,
   input  logic [15:0] ocnt_i,
   input  logic [1:0]  exp_vld_i,
   input  logic [1:0]  vld_i,
   input  logic [64:0] exp_src_word_i,
   input  logic [64:0] src_word_i,
   input  logic [64:0] exp_dst_word_i,
   input  logic [64:0] dst_word_i,
   input  logic        test_done_i,
   input  int          test_idx_i,
   input  logic        run_done_i,
   output int          err_cnt_o,
   output logic        timeout_o
);

   timeunit 1ns;
   timeprecision 1ps;

   localparam int TEST_CYCLES    = 400;
   localparam int NUM_TESTS      = 6;
   localparam int TIMEOUT_CYCLES = NUM_TESTS * TEST_CYCLES + 200;

   int         err_cnt = 0;
   int         check_cnt = 0;
   int         test_cnt = 0;
   int         test_err_base = 0;
   int         cycle_cnt = 0;
   logic       timed_out = 1'b0;
   logic [7:0] exp_flags;

   assign err_cnt_o = err_cnt;
   assign timeout_o = timed_out;

   function automatic string test_name(int idx);
      case (idx)
         0:       return "source path order";
         1:       return "destination path order";
         2:       return "level flags";
         3:       return "port contention";
         4:       return "output counter";
         default: return "reset mid-traffic";
      endcase
   endfunction

   task automatic compare(string what, logic [64:0] exp, logic [64:0] act);
      check_cnt++;
      if (act !== exp)
      begin
         err_cnt++;
         $display("CHECK FAILED %s: %s expected %h actual %h", test_name(test_idx_i),
                  what, exp, act);
      end
   endtask

   task automatic check_read(string side, logic exp_vld, logic vld, logic [64:0] exp,
                             logic [64:0] act);
      if (exp_vld !== vld)
      begin
         err_cnt++;
         $display("ERROR %s: %s valid pulse %s", test_name(test_idx_i), side,
                  vld ? "came without an accepted read" : "missing after an accepted read");
      end
      else if (vld)
         compare({side, " word"}, exp, act);
   endtask

   //##############################
   // per cycle comparison
   //##############################

   // outputs settle long before the falling edge.
   always @(negedge wb_clk_i)
   begin
      if (check_en_i)
      begin
         exp_flags = {src_cnt_i >= `CH_AF_LEVEL, src_cnt_i < `CH_HALF_LEVEL,
                      dst_cnt_i <= `CH_AE_LEVEL,
                      dst_cnt_i >= `CH_HALF_LEVEL || (!m_end_n_i && dst_cnt_i != 0),
                      src_cnt_i <= `CH_AE_LEVEL, src_cnt_i == 0,
                      dst_cnt_i >= `CH_AF_LEVEL, dst_cnt_i == `CH_DEPTH};
         compare("level flags", 65'(exp_flags), 65'(flags_i));
         compare("ocnt_o", 65'(exp_ocnt_i), 65'(ocnt_i));
         check_read("source", exp_vld_i[1], vld_i[1], exp_src_word_i, src_word_i);
         check_read("destination", exp_vld_i[0], vld_i[0], exp_dst_word_i, dst_word_i);
      end
      if (test_done_i)
      begin
         test_cnt++;
         $display("test %0d %s: %s, %0d errors", test_idx_i + 1, test_name(test_idx_i),
                  (err_cnt == test_err_base) ? "passed" : "failed", err_cnt - test_err_base);
         test_err_base = err_cnt;
      end
      if (run_done_i)
         $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
   end

   always @(posedge wb_clk_i)
   begin
      cycle_cnt++;
      if (cycle_cnt == TIMEOUT_CYCLES)
      begin
         timed_out <= 1'b1;
         $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      end
   end

endmodule

//--- verif/tb_top.sv
//##############################
// dma channel testbench with seeded
// random traffic and a fifo model.
//##############################

`include "dma_ch_defines.svh"

module tb_top;

   timeunit 1ns;
   timeprecision 1ps;

   //##############################
   // dut ports
   //##############################

   logic        wb_clk_i;
   logic        m_reset;
   logic        src_xfer_i;
   logic        src_last_i;
   logic [31:0] src_dat_i;
   logic [31:0] src_dat64_i;
   logic        src_stop_o;
   logic        src_start_o;
   logic        dst_xfer_i;
   logic [31:0] dst_dat_o;
   logic [31:0] dst_dat64_o;
   logic        dst_vld_o;
   logic        dst_end_o;
   logic        dst_stop_o;
   logic        dst_start_o;
   logic        m_src_getn_i;
   logic [63:0] m_src_o;
   logic        m_src_last_o;
   logic        m_src_vld_o;
   logic        m_src_almost_empty_o;
   logic        m_src_empty_o;
   logic        m_dst_putn_i;
   logic [63:0] m_dst_i;
   logic        m_dst_last_i;
   logic        m_dst_almost_full_o;
   logic        m_dst_full_o;
   logic        m_end_n_i;
   logic [15:0] ocnt_o;

   //##############################
   // fifo model
   //##############################

   logic [64:0] src_q [$];               // words as {last, hi, lo} in write order.
   logic [64:0] dst_q [$];
   int          src_cnt;
   int          dst_cnt;
   logic [15:0] ocnt_model;
   logic [1:0]  exp_vld;                 // source and destination pulses due this cycle.
   logic [64:0] exp_src_word;
   logic [64:0] exp_dst_word;
   logic        src_wacc;
   logic        src_racc;
   logic        dst_wacc;
   logic        dst_racc;
   int          seed;
   logic        check_en;
   logic        test_done;
   int          test_idx;
   logic        run_done;
   int          err_cnt;
   logic        timeout;

   dma_ch dut0 (.*);

   ch_checker chk0
   (
      .wb_clk_i       (wb_clk_i),
      .check_en_i     (check_en),
      .m_end_n_i      (m_end_n_i),
      .src_cnt_i      (src_cnt),
      .dst_cnt_i      (dst_cnt),
      .flags_i        ({src_stop_o, src_start_o, dst_stop_o, dst_start_o,
                        m_src_almost_empty_o, m_src_empty_o, m_dst_almost_full_o,
                        m_dst_full_o}),
      .exp_ocnt_i     (ocnt_model),
      .ocnt_i         (ocnt_o),
      .exp_vld_i      (exp_vld),
      .vld_i          ({m_src_vld_o, dst_vld_o}),
      .exp_src_word_i (exp_src_word),
      .src_word_i     ({m_src_last_o, m_src_o}),
      .exp_dst_word_i (exp_dst_word),
      .dst_word_i     ({dst_end_o, dst_dat64_o, dst_dat_o}),
      .test_done_i    (test_done),
      .test_idx_i     (test_idx),
      .run_done_i     (run_done),
      .err_cnt_o      (err_cnt),
      .timeout_o      (timeout)
   );

   initial
   begin
      wb_clk_i = 1'b0;
      forever
         #20 wb_clk_i = ~wb_clk_i;
   end

   // true with the given chance in percent.
   function automatic logic chance(int pct);
      int r;
      r = $random(seed);
      return ((r & 32'h7fff_ffff) % 100) < pct;
   endfunction

   //##############################
   // cycle driver
   //##############################

   // the model takes last cycle's accepts at the edge, then new inputs follow 2 ns later.
   task automatic run_phase(int cycles, int pw_src, int pr_src, int pw_dst, int pr_dst,
                            int end_low, logic fill, logic rst);
      repeat (cycles)
      begin
         @(posedge wb_clk_i);
         exp_vld = m_reset ? 2'b00 : {src_racc, dst_racc};
         if (m_reset)
         begin
            src_q.delete();
            dst_q.delete();
            ocnt_model = '0;
         end
         else
         begin
            if (src_racc)
               exp_src_word = src_q.pop_front();
            if (dst_racc)
               exp_dst_word = dst_q.pop_front();
            if (src_wacc)
               src_q.push_back({src_last_i, src_dat64_i, src_dat_i});
            if (dst_wacc)
               dst_q.push_back({m_dst_last_i, m_dst_i});
            if (dst_wacc && !m_dst_last_i)
               ocnt_model = ocnt_model + 1'b1;
         end
         src_cnt = src_q.size();
         dst_cnt = dst_q.size();
         #2;
         m_reset      = rst;
         // in fill mode the engine keeps writing past the stop level until full.
         src_xfer_i   = chance(pw_src) && (fill ? src_cnt < `CH_DEPTH : !src_stop_o);
         src_last_i   = chance(25);
         src_dat_i    = $random(seed);
         src_dat64_i  = $random(seed);
         m_src_getn_i = !chance(pr_src);
         m_dst_putn_i = !(chance(pw_dst) && !m_dst_full_o);
         m_dst_i      = {$random(seed), $random(seed)};
         m_dst_last_i = chance(25);
         dst_xfer_i   = chance(pr_dst);
         m_end_n_i    = !chance(end_low);
         src_wacc = !rst && src_xfer_i && src_cnt != `CH_DEPTH;
         dst_wacc = !rst && !m_dst_putn_i && dst_cnt != `CH_DEPTH;
         src_racc = !rst && !m_src_getn_i && src_cnt != 0 && !dst_wacc;  // port b is shared.
         dst_racc = !rst && dst_xfer_i && dst_cnt != 0 && !src_wacc;      // port a is shared.
      end
   endtask

   task automatic end_test();
      run_phase(1, 0, 0, 0, 0, 0, 1'b0, 1'b0);      // the last read pulses still arrive.
      test_done = 1'b1;
      run_phase(1, 0, 0, 0, 0, 0, 1'b0, 1'b0);
      test_done = 1'b0;
   endtask

   //##############################
   // test sequence
   //##############################

   initial
   begin
      seed         = 32'h1e14513e;
      m_reset      = 1'b1;
      src_xfer_i   = 1'b0;
      src_last_i   = 1'b0;
      src_dat_i    = '0;
      src_dat64_i  = '0;
      dst_xfer_i   = 1'b0;
      m_src_getn_i = 1'b1;
      m_dst_putn_i = 1'b1;
      m_dst_i      = '0;
      m_dst_last_i = 1'b0;
      m_end_n_i    = 1'b1;
      src_wacc     = 1'b0;
      src_racc     = 1'b0;
      dst_wacc     = 1'b0;
      dst_racc     = 1'b0;
      exp_vld      = '0;
      exp_src_word = '0;
      exp_dst_word = '0;
      ocnt_model   = '0;
      src_cnt      = 0;
      dst_cnt      = 0;
      check_en     = 1'b0;
      test_done    = 1'b0;
      test_idx     = 0;
      run_done     = 1'b0;
      run_phase(2, 0, 0, 0, 0, 0, 1'b0, 1'b1);      // reset is already high for the first edge.
      check_en = 1'b1;
      test_idx = 0;
      run_phase(300, 60, 50, 0, 0, 0, 1'b0, 1'b0);
      end_test();
      test_idx = 1;
      run_phase(300, 0, 0, 60, 50, 0, 1'b0, 1'b0);
      end_test();
      test_idx = 2;
      run_phase(120, 90, 0, 90, 0, 30, 1'b1, 1'b0);  // fill both fifos to full.
      run_phase(120, 0, 90, 0, 90, 30, 1'b1, 1'b0);  // and drain them back to empty.
      end_test();
      test_idx = 3;
      run_phase(300, 80, 80, 80, 80, 0, 1'b0, 1'b0);
      end_test();
      test_idx = 4;
      run_phase(300, 20, 20, 70, 40, 0, 1'b0, 1'b0);
      end_test();
      test_idx = 5;
      run_phase(100, 60, 50, 60, 50, 0, 1'b0, 1'b0);
      run_phase(3, 0, 0, 0, 0, 0, 1'b0, 1'b1);
      run_phase(150, 60, 50, 60, 50, 0, 1'b0, 1'b0);
      end_test();
      run_done = 1'b1;
      @(negedge wb_clk_i);
      #1;
      if (err_cnt == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

   initial
   begin
      @(posedge timeout);
      $display("Something failed");
      $finish;
   end

endmodule
